//--- uart_pkg.sv
package uart_pkg;

	// Oversampling and divider
	localparam int OVERSAMPLE = 8;
	localparam int W_OVER = $clog2(OVERSAMPLE);
	localparam int W_DIV_INT = 10;
	localparam int W_DIV_FRAC = 8;

	// FIFOs
	localparam int FIFO_DEPTH = 2;
	localparam int W_FLEVEL = $clog2(FIFO_DEPTH + 1);

	// Register map
	localparam logic [15:0] ADDR_CSR = 16'h0000;
	localparam logic [15:0] ADDR_DIV = 16'h0004;
	localparam logic [15:0] ADDR_FSTAT = 16'h0008;
	localparam logic [15:0] ADDR_TX = 16'h000c;
	localparam logic [15:0] ADDR_RX = 16'h0010;

	// CSR bits, busy is read only
	localparam int CSR_EN_BIT = 0;
	localparam int CSR_BUSY_BIT = 1;
	localparam int CSR_TXIE_BIT = 4;
	localparam int CSR_RXIE_BIT = 5;
	localparam int CSR_LOOPBACK_BIT = 8;

	// DIV fields
	localparam int DIV_FRAC_LSB = 0;
	localparam int DIV_INT_LSB = 16;

	// FSTAT fields for TX, RX is the same layout moved up
	localparam int FSTAT_LEVEL_LSB = 0;
	localparam int FSTAT_FULL_BIT = 8;
	localparam int FSTAT_EMPTY_BIT = 9;
	localparam int FSTAT_OVER_BIT = 10;
	localparam int FSTAT_UNDER_BIT = 11;
	localparam int FSTAT_RX_SHIFT = 16;

	// Line engine states, 2 to 9 are the data bits
	localparam int W_STATE = 4;
	localparam logic [W_STATE-1:0] ST_IDLE = 4'd0;
	localparam logic [W_STATE-1:0] ST_START = 4'd1;
	localparam logic [W_STATE-1:0] ST_STOP = 4'd10;

endpackage

//--- clkdiv_frac.sv
`timescale 1ns/1ps

module clkdiv_frac import uart_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  en_i,
	input  logic [W_DIV_INT-1:0]  div_int_i,
	input  logic [W_DIV_FRAC-1:0] div_frac_i,
	output logic                  tick_o
);

	logic [W_DIV_INT-1:0]  ctr;
	logic [W_DIV_FRAC-1:0] frac_acc;
	logic [W_DIV_FRAC:0]   frac_sum;

	// Top bit is the fraction carry, which stretches the next period by one
	assign frac_sum = {1'b0, frac_acc} + {1'b0, div_frac_i};
	assign tick_o = en_i && (ctr == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctr <= '0;
			frac_acc <= '0;
		end else if (!en_i) begin
			ctr <= '0;
			frac_acc <= '0;
		end else if (ctr == '0) begin
			frac_acc <= frac_sum[W_DIV_FRAC-1:0];
			ctr <= div_int_i - 1'b1 + {{(W_DIV_INT-1){1'b0}}, frac_sum[W_DIV_FRAC]};
		end else begin
			ctr <= ctr - 1'b1;
		end
	end

endmodule

//--- sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 2
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [WIDTH-1:0]           wdata_i,
	input  logic                       wen_i,
	output logic [WIDTH-1:0]           rdata_o,
	input  logic                       ren_i,
	output logic                       full_o,
	output logic                       empty_o,
	output logic [$clog2(DEPTH+1)-1:0] level_o
);

	localparam int W_PTR = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	// Extra top bit tells full from empty when the indices match
	logic [W_PTR:0]   wptr;
	logic [W_PTR:0]   rptr;
	logic             do_write;
	logic             do_read;

	assign full_o = (wptr[W_PTR] != rptr[W_PTR]) &&
		(wptr[W_PTR-1:0] == rptr[W_PTR-1:0]);
	assign empty_o = (wptr == rptr);
	assign level_o = wptr - rptr;
	assign rdata_o = mem[rptr[W_PTR-1:0]];

	assign do_write = wen_i && !full_o;
	assign do_read = ren_i && !empty_o;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (do_write)
				wptr <= wptr + 1'b1;
			if (do_read)
				rptr <= rptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_write)
			mem[wptr[W_PTR-1:0]] <= wdata_i;
	end

endmodule

//--- uart_regs.sv
`timescale 1ns/1ps

module uart_regs import uart_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic                  apb_psel_i,
	input  logic                  apb_penable_i,
	input  logic                  apb_pwrite_i,
	input  logic [15:0]           apb_paddr_i,
	input  logic [31:0]           apb_pwdata_i,
	output logic [31:0]           apb_prdata_o,
	output logic                  apb_pready_o,
	output logic                  apb_pslverr_o,

	output logic                  en_o,
	output logic                  txie_o,
	output logic                  rxie_o,
	output logic                  loopback_o,
	output logic [W_DIV_INT-1:0]  div_int_o,
	output logic [W_DIV_FRAC-1:0] div_frac_o,

	input  logic                  busy_i,
	input  logic [W_FLEVEL-1:0]   tx_level_i,
	input  logic                  tx_full_i,
	input  logic                  tx_empty_i,
	input  logic                  tx_over_i,
	input  logic                  tx_under_i,
	input  logic [W_FLEVEL-1:0]   rx_level_i,
	input  logic                  rx_full_i,
	input  logic                  rx_empty_i,
	input  logic                  rx_over_i,
	input  logic                  rx_under_i,

	output logic [7:0]            tx_data_o,
	output logic                  tx_push_o,
	input  logic [7:0]            rx_data_i,
	output logic                  rx_pop_o
);

	logic access;
	logic wen;
	logic ren;
	logic sel_csr;
	logic sel_div;
	logic sel_fstat;
	logic sel_tx;
	logic sel_rx;
	logic clr_fstat;
	logic tx_over_q;
	logic tx_under_q;
	logic rx_over_q;
	logic rx_under_q;

	// One 16 bit half of FSTAT
	function automatic logic [15:0] fstat_half(
		input logic [W_FLEVEL-1:0] level,
		input logic                full,
		input logic                empty,
		input logic                over,
		input logic                under
	);
		logic [15:0] f;
		f = '0;
		f[FSTAT_LEVEL_LSB +: W_FLEVEL] = level;
		f[FSTAT_FULL_BIT] = full;
		f[FSTAT_EMPTY_BIT] = empty;
		f[FSTAT_OVER_BIT] = over;
		f[FSTAT_UNDER_BIT] = under;
		return f;
	endfunction

	// ==============================
	// Decode
	// ==============================

	assign access = apb_psel_i && apb_penable_i;
	assign wen = access && apb_pwrite_i;
	assign ren = access && !apb_pwrite_i;

	assign sel_csr = (apb_paddr_i == ADDR_CSR);
	assign sel_div = (apb_paddr_i == ADDR_DIV);
	assign sel_fstat = (apb_paddr_i == ADDR_FSTAT);
	assign sel_tx = (apb_paddr_i == ADDR_TX);
	assign sel_rx = (apb_paddr_i == ADDR_RX);

	assign apb_pready_o = 1'b1;
	assign apb_pslverr_o = access && !(sel_csr || sel_div || sel_fstat || sel_tx || sel_rx);

	// FIFO strobes land on the edge that closes the access cycle
	assign tx_data_o = apb_pwdata_i[7:0];
	assign tx_push_o = wen && sel_tx;
	assign rx_pop_o = ren && sel_rx;

	always_comb begin
		apb_prdata_o = '0;
		if (sel_csr) begin
			apb_prdata_o[CSR_EN_BIT] = en_o;
			apb_prdata_o[CSR_BUSY_BIT] = busy_i;
			apb_prdata_o[CSR_TXIE_BIT] = txie_o;
			apb_prdata_o[CSR_RXIE_BIT] = rxie_o;
			apb_prdata_o[CSR_LOOPBACK_BIT] = loopback_o;
		end else if (sel_div) begin
			apb_prdata_o[DIV_FRAC_LSB +: W_DIV_FRAC] = div_frac_o;
			apb_prdata_o[DIV_INT_LSB +: W_DIV_INT] = div_int_o;
		end else if (sel_fstat) begin
			apb_prdata_o[15:0] = fstat_half(tx_level_i, tx_full_i, tx_empty_i,
				tx_over_q, tx_under_q);
			apb_prdata_o[FSTAT_RX_SHIFT +: 16] = fstat_half(rx_level_i, rx_full_i,
				rx_empty_i, rx_over_q, rx_under_q);
		end else if (sel_rx) begin
			apb_prdata_o[7:0] = rx_data_i;
		end
	end

	// ==============================
	// Control and sticky flags
	// ==============================

	assign clr_fstat = wen && sel_fstat;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			en_o <= 1'b0;
			txie_o <= 1'b0;
			rxie_o <= 1'b0;
			loopback_o <= 1'b0;
			div_int_o <= '0;
			div_frac_o <= '0;
			tx_over_q <= 1'b0;
			tx_under_q <= 1'b0;
			rx_over_q <= 1'b0;
			rx_under_q <= 1'b0;
		end else begin
			if (wen && sel_csr) begin
				en_o <= apb_pwdata_i[CSR_EN_BIT];
				txie_o <= apb_pwdata_i[CSR_TXIE_BIT];
				rxie_o <= apb_pwdata_i[CSR_RXIE_BIT];
				loopback_o <= apb_pwdata_i[CSR_LOOPBACK_BIT];
			end
			if (wen && sel_div) begin
				div_frac_o <= apb_pwdata_i[DIV_FRAC_LSB +: W_DIV_FRAC];
				div_int_o <= apb_pwdata_i[DIV_INT_LSB +: W_DIV_INT];
			end
			// A new event wins over a clear in the same cycle
			tx_over_q <= tx_over_i ||
				(tx_over_q && !(clr_fstat && apb_pwdata_i[FSTAT_OVER_BIT]));
			tx_under_q <= tx_under_i ||
				(tx_under_q && !(clr_fstat && apb_pwdata_i[FSTAT_UNDER_BIT]));
			rx_over_q <= rx_over_i || (rx_over_q &&
				!(clr_fstat && apb_pwdata_i[FSTAT_RX_SHIFT + FSTAT_OVER_BIT]));
			rx_under_q <= rx_under_i || (rx_under_q &&
				!(clr_fstat && apb_pwdata_i[FSTAT_RX_SHIFT + FSTAT_UNDER_BIT]));
		end
	end

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       en_i,
	input  logic       tick_i,
	input  logic [7:0] fifo_data_i,
	input  logic       fifo_empty_i,
	output logic       fifo_pop_o,
	output logic       busy_o,
	output logic       tx_o
);

	logic [W_OVER-1:0]  over_ctr;
	logic [W_STATE-1:0] state;
	logic [7:0]         shifter;
	logic               bit_edge;

	// A bit boundary is the tick that wraps the oversample counter
	assign bit_edge = tick_i && (over_ctr == '0);
	assign fifo_pop_o = en_i && bit_edge && !fifo_empty_i &&
		((state == ST_IDLE) || (state == ST_STOP));
	assign busy_o = (state != ST_IDLE) || !fifo_empty_i;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_o <= 1'b1;
			over_ctr <= '0;
			state <= ST_IDLE;
			shifter <= '0;
		end else if (!en_i) begin
			tx_o <= 1'b1;
			over_ctr <= '0;
			state <= ST_IDLE;
			shifter <= '0;
		end else begin
			if (tick_i)
				over_ctr <= over_ctr + 1'b1;
			if (bit_edge) begin
				state <= state + 1'b1;
				case (state)
				ST_IDLE: begin
					if (fifo_empty_i) begin
						// Counter parked at zero so a new byte starts on the next tick
						over_ctr <= '0;
						state <= ST_IDLE;
					end else begin
						shifter <= fifo_data_i;
						tx_o <= 1'b0;
					end
				end
				ST_STOP: begin
					if (fifo_empty_i) begin
						over_ctr <= '0;
						state <= ST_IDLE;
					end else begin
						// Next frame follows straight on
						shifter <= fifo_data_i;
						state <= ST_START;
						tx_o <= 1'b0;
					end
				end
				default: begin
					// Start and data states, the last data state drives the stop bit
					shifter <= shifter >> 1;
					tx_o <= (state == ST_STOP - 1'b1) ? 1'b1 : shifter[0];
				end
				endcase
			end
		end
	end

endmodule

//--- uart_rx.sv
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       en_i,
	input  logic       tick_i,
	input  logic       rx_i,
	output logic       push_o,
	output logic [7:0] data_o
);

	logic [1:0]         din_prev;
	logic               din;
	logic [W_OVER-1:0]  over_ctr;
	logic [W_STATE-1:0] state;
	logic               bit_edge;

	// ==============================
	// Glitch filter
	// ==============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			din_prev <= 2'b11;
			din <= 1'b1;
		end else begin
			din_prev <= {din_prev[0], rx_i};
			// Level moves only on three equal samples
			if (&{rx_i, din_prev})
				din <= 1'b1;
			else if (~|{rx_i, din_prev})
				din <= 1'b0;
		end
	end

	// ==============================
	// Receive FSM
	// ==============================

	assign bit_edge = tick_i && (over_ctr == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			over_ctr <= '0;
			state <= ST_IDLE;
			data_o <= '0;
			push_o <= 1'b0;
		end else if (!en_i) begin
			over_ctr <= '0;
			state <= ST_IDLE;
			data_o <= '0;
			push_o <= 1'b0;
		end else begin
			push_o <= 1'b0;
			if (tick_i)
				over_ctr <= over_ctr + 1'b1;
			if (bit_edge) begin
				state <= state + 1'b1;
				case (state)
				ST_IDLE: begin
					if (din) begin
						over_ctr <= '0;
						state <= ST_IDLE;
					end
				end
				ST_START: begin
					// Half a bit more so data is sampled mid-bit
					over_ctr <= W_OVER'(OVERSAMPLE / 2);
				end
				ST_STOP: begin
					// Frame with a low stop bit is dropped
					push_o <= din;
					over_ctr <= '0;
					state <= ST_IDLE;
				end
				default: begin
					data_o <= {din, data_o[7:1]};
				end
				endcase
			end
		end
	end

endmodule

//--- uart_mini.sv
`timescale 1ns/1ps

module uart_mini import uart_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,

	input  logic        apb_psel_i,
	input  logic        apb_penable_i,
	input  logic        apb_pwrite_i,
	input  logic [15:0] apb_paddr_i,
	input  logic [31:0] apb_pwdata_i,
	output logic [31:0] apb_prdata_o,
	output logic        apb_pready_o,
	output logic        apb_pslverr_o,

	input  logic        rx_i,
	output logic        tx_o,
	output logic        irq_o,
	output logic        dreq_o
);

	logic                  en;
	logic                  txie;
	logic                  rxie;
	logic                  loopback;
	logic [W_DIV_INT-1:0]  div_int;
	logic [W_DIV_FRAC-1:0] div_frac;
	logic                  tick;
	logic                  tx_busy;
	logic                  rx_line;

	logic [7:0]            txf_wdata;
	logic                  txf_push;
	logic [7:0]            txf_rdata;
	logic                  txf_pop;
	logic                  txf_full;
	logic                  txf_empty;
	logic [W_FLEVEL-1:0]   txf_level;

	logic [7:0]            rxf_wdata;
	logic                  rxf_push;
	logic [7:0]            rxf_rdata;
	logic                  rxf_pop;
	logic                  rxf_full;
	logic                  rxf_empty;
	logic [W_FLEVEL-1:0]   rxf_level;

	// Loopback feeds our own tx into the receiver
	assign rx_line = loopback ? tx_o : rx_i;

	// Interrupt held low while the UART is disabled
	assign irq_o = en && ((txie && !txf_full) || (rxie && !rxf_empty));
	assign dreq_o = irq_o;

	clkdiv_frac clkdiv_frac_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.en_i       (en),
		.div_int_i  (div_int),
		.div_frac_i (div_frac),
		.tick_o     (tick)
	);

	sync_fifo #(.WIDTH(8), .DEPTH(FIFO_DEPTH)) tx_fifo_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.wdata_i (txf_wdata),
		.wen_i   (txf_push),
		.rdata_o (txf_rdata),
		.ren_i   (txf_pop),
		.full_o  (txf_full),
		.empty_o (txf_empty),
		.level_o (txf_level)
	);

	sync_fifo #(.WIDTH(8), .DEPTH(FIFO_DEPTH)) rx_fifo_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.wdata_i (rxf_wdata),
		.wen_i   (rxf_push),
		.rdata_o (rxf_rdata),
		.ren_i   (rxf_pop),
		.full_o  (rxf_full),
		.empty_o (rxf_empty),
		.level_o (rxf_level)
	);

	uart_regs uart_regs_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.apb_psel_i    (apb_psel_i),
		.apb_penable_i (apb_penable_i),
		.apb_pwrite_i  (apb_pwrite_i),
		.apb_paddr_i   (apb_paddr_i),
		.apb_pwdata_i  (apb_pwdata_i),
		.apb_prdata_o  (apb_prdata_o),
		.apb_pready_o  (apb_pready_o),
		.apb_pslverr_o (apb_pslverr_o),
		.en_o          (en),
		.txie_o        (txie),
		.rxie_o        (rxie),
		.loopback_o    (loopback),
		.div_int_o     (div_int),
		.div_frac_o    (div_frac),
		.busy_i        (tx_busy),
		.tx_level_i    (txf_level),
		.tx_full_i     (txf_full),
		.tx_empty_i    (txf_empty),
		.tx_over_i     (txf_full && txf_push),
		.tx_under_i    (txf_empty && txf_pop),
		.rx_level_i    (rxf_level),
		.rx_full_i     (rxf_full),
		.rx_empty_i    (rxf_empty),
		.rx_over_i     (rxf_full && rxf_push),
		.rx_under_i    (rxf_empty && rxf_pop),
		.tx_data_o     (txf_wdata),
		.tx_push_o     (txf_push),
		.rx_data_i     (rxf_rdata),
		.rx_pop_o      (rxf_pop)
	);

	uart_tx uart_tx_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.en_i         (en),
		.tick_i       (tick),
		.fifo_data_i  (txf_rdata),
		.fifo_empty_i (txf_empty),
		.fifo_pop_o   (txf_pop),
		.busy_o       (tx_busy),
		.tx_o         (tx_o)
	);

	uart_rx uart_rx_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.en_i   (en),
		.tick_i (tick),
		.rx_i   (rx_line),
		.push_o (rxf_push),
		.data_o (rxf_wdata)
	);

endmodule

//--- tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk,
	output logic rst_n
);

	localparam int PERIOD_NS = 10;
	localparam int RESET_CYCLES = 5;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset held for a few cycles, released on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

//--- tb_uart_mini.sv
`timescale 1ns/1ps

module tb_uart_mini import uart_pkg::*; ();

	localparam int DIV_INT = 2;
	localparam int BIT_CYCLES = DIV_INT * OVERSAMPLE;
	localparam int N_TX = 6;
	localparam int N_RX_ROUNDS = 2;
	localparam int N_LOOP_ROUNDS = 2;
	// Transmit, receive, bad and good frame, drained TX FIFO plus one, loopback
	localparam int N_FRAMES = N_TX + FIFO_DEPTH * N_RX_ROUNDS + 2 + FIFO_DEPTH + 1 +
		FIFO_DEPTH * N_LOOP_ROUNDS;
	localparam int WATCHDOG_CYCLES = 3 * N_FRAMES * 10 * BIT_CYCLES + 4000;
	localparam int POLL_LIMIT = 400;
	localparam int DRAIN_LIMIT = (FIFO_DEPTH + 2) * 10 * BIT_CYCLES;

	localparam logic [31:0] CSR_EN = 32'(1) << CSR_EN_BIT;
	localparam logic [31:0] CSR_TXIE = 32'(1) << CSR_TXIE_BIT;
	localparam logic [31:0] CSR_RXIE = 32'(1) << CSR_RXIE_BIT;
	localparam logic [31:0] CSR_LOOP = 32'(1) << CSR_LOOPBACK_BIT;
	localparam logic [31:0] DIV_MASK = (((32'(1) << W_DIV_INT) - 1) << DIV_INT_LSB) |
		(((32'(1) << W_DIV_FRAC) - 1) << DIV_FRAC_LSB);

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [15:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        rx;
	logic        tx;
	logic        irq;
	logic        dreq;

	logic [31:0] rng_state = 32'h5dcd_4448;
	logic [31:0] csr_model;
	logic [7:0]  tx_expect[$];
	logic [7:0]  rx_expect[$];
	int          error_count = 0;
	int          errors_before = 0;
	int          test_count = 0;
	int          failed_tests = 0;

	tb_clkgen clkgen_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	uart_mini uart_mini_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.apb_psel_i    (psel),
		.apb_penable_i (penable),
		.apb_pwrite_i  (pwrite),
		.apb_paddr_i   (paddr),
		.apb_pwdata_i  (pwdata),
		.apb_prdata_o  (prdata),
		.apb_pready_o  (pready),
		.apb_pslverr_o (pslverr),
		.rx_i          (rx),
		.tx_o          (tx),
		.irq_o         (irq),
		.dreq_o        (dreq)
	);

	// ==============================
	// Helpers
	// ==============================

	function logic [7:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state[31:24];
	endfunction

	function automatic logic irq_rule(input logic [31:0] csr, input logic tx_full,
		input logic rx_empty);
		return csr[CSR_EN_BIT] &&
			((csr[CSR_TXIE_BIT] && !tx_full) || (csr[CSR_RXIE_BIT] && !rx_empty));
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			error_count++;
		end
	endtask

	// Setup cycle, then one access cycle since pready is tied high
	task automatic bus_access(input logic wr, input logic [15:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		rdata = prdata;
		err = pslverr;
		check_value("apb_pready_o", 32'(pready), 32'd1);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		logic        err;
		bus_access(1'b1, addr, data, unused, err);
		check_value("apb_pslverr_o", 32'(err), 32'd0);
	endtask

	task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
		logic err;
		bus_access(1'b0, addr, 32'd0, data, err);
		check_value("apb_pslverr_o", 32'(err), 32'd0);
	endtask

	task automatic set_csr(input logic [31:0] value);
		write_reg(ADDR_CSR, value);
		csr_model = value;
	endtask

	task automatic check_irq(input logic tx_full, input logic rx_empty);
		logic exp;
		exp = irq_rule(csr_model, tx_full, rx_empty);
		@(negedge clk);
		check_value("irq_o", 32'(irq), 32'(exp));
		check_value("dreq_o", 32'(dreq), 32'(exp));
	endtask

	task automatic send_frame(input logic [7:0] b, input logic stop);
		logic [9:0] bits;
		bits = {stop, b, 1'b0};
		@(posedge clk);
		for (int i = 0; i < 10; i++) begin
			rx <= bits[i];
			repeat (BIT_CYCLES) @(posedge clk);
		end
		rx <= 1'b1;
	endtask

	task automatic push_tx(input logic [7:0] b);
		logic [31:0] fstat;
		int          polls;
		polls = 0;
		read_reg(ADDR_FSTAT, fstat);
		while (fstat[FSTAT_FULL_BIT] && polls < POLL_LIMIT) begin
			read_reg(ADDR_FSTAT, fstat);
			polls++;
		end
		assert (polls < POLL_LIMIT) else begin
			$display("Timeout at %0t ns: TX FIFO stayed full", $time);
			error_count++;
		end
		write_reg(ADDR_TX, 32'(b));
		tx_expect.push_back(b);
	endtask

	task automatic wait_rx_count(input int n);
		logic [31:0] fstat;
		int          polls;
		polls = 0;
		read_reg(ADDR_FSTAT, fstat);
		while (fstat[FSTAT_RX_SHIFT +: 8] != n && polls < POLL_LIMIT) begin
			read_reg(ADDR_FSTAT, fstat);
			polls++;
		end
		assert (polls < POLL_LIMIT) else begin
			$display("Timeout at %0t ns: RX FIFO never held %0d bytes", $time, n);
			error_count++;
		end
	endtask

	task automatic wait_tx_drained();
		int cycles;
		cycles = 0;
		while (tx_expect.size() != 0 && cycles < DRAIN_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		assert (cycles < DRAIN_LIMIT) else begin
			$display("Timeout at %0t ns: %0d written bytes never left on tx_o",
				$time, tx_expect.size());
			error_count++;
		end
	endtask

	task automatic check_rx_status(input int n);
		logic [31:0] fstat;
		read_reg(ADDR_FSTAT, fstat);
		check_value("rx level", 32'(fstat[FSTAT_RX_SHIFT +: 8]), 32'(n));
		check_value("rx empty", 32'(fstat[FSTAT_RX_SHIFT + FSTAT_EMPTY_BIT]), 32'(n == 0));
		check_value("rx full", 32'(fstat[FSTAT_RX_SHIFT + FSTAT_FULL_BIT]),
			32'(n == FIFO_DEPTH));
	endtask

	task automatic read_rx_byte();
		logic [31:0] data;
		read_reg(ADDR_RX, data);
		check_value("rx data", data, 32'(rx_expect.pop_front()));
	endtask

	task automatic finish_test(input string name);
		int errs;
		errs = error_count - errors_before;
		test_count++;
		if (errs == 0) begin
			$display("Test %0d %s: ok", test_count, name);
		end else begin
			$display("Test %0d %s: FAIL with %0d errors", test_count, name, errs);
			failed_tests++;
		end
		errors_before = error_count;
	endtask

	// ==============================
	// Serial decoder on tx_o
	// ==============================

	initial begin
		logic [7:0] frame_byte;
		forever begin
			@(negedge tx);
			repeat (BIT_CYCLES / 2) @(negedge clk);
			assert (tx == 1'b0) else begin
				$display("Start bit on tx_o did not stay low at %0t ns", $time);
				error_count++;
			end
			for (int i = 0; i < 8; i++) begin
				repeat (BIT_CYCLES) @(negedge clk);
				frame_byte[i] = tx;
			end
			repeat (BIT_CYCLES) @(negedge clk);
			assert (tx == 1'b1) else begin
				$display("Stop bit on tx_o was low at %0t ns", $time);
				error_count++;
			end
			assert (tx_expect.size() != 0) else begin
				$display("Frame 0x%0h on tx_o at %0t ns with no byte written", frame_byte, $time);
				error_count++;
			end
			if (tx_expect.size() != 0)
				check_value("tx_o byte", 32'(frame_byte), 32'(tx_expect.pop_front()));
		end
	end

	// Watchdog sized from the frame count of all tests
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

	// ==============================
	// Tests
	// ==============================

	initial begin
		logic [31:0] data;
		logic [31:0] value;
		logic [31:0] fstat;
		logic        err;
		logic [7:0]  b;

		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rx = 1'b1;
		csr_model = '0;
		@(posedge rst_n);
		@(posedge clk);

		// Reset state, register readback and decode errors
		@(negedge clk);
		check_value("tx_o", 32'(tx), 32'd1);
		check_irq(1'b0, 1'b1);
		set_csr(CSR_TXIE | CSR_RXIE | CSR_LOOP | (32'(1) << CSR_BUSY_BIT));
		csr_model = CSR_TXIE | CSR_RXIE | CSR_LOOP;
		read_reg(ADDR_CSR, data);
		check_value("CSR", data, csr_model);
		check_irq(1'b0, 1'b1);
		value = {next_random(), next_random(), next_random(), next_random()};
		write_reg(ADDR_DIV, value);
		read_reg(ADDR_DIV, data);
		check_value("DIV", data, value & DIV_MASK);
		write_reg(ADDR_DIV, 32'(DIV_INT) << DIV_INT_LSB);
		read_reg(ADDR_DIV, data);
		check_value("DIV", data, 32'(DIV_INT) << DIV_INT_LSB);
		bus_access(1'b0, 16'h0014, 32'd0, data, err);
		check_value("apb_pslverr_o", 32'(err), 32'd1);
		bus_access(1'b1, 16'h0020, 32'hffff_ffff, data, err);
		check_value("apb_pslverr_o", 32'(err), 32'd1);
		set_csr(32'd0);
		finish_test("reset and registers");

		// Transmit
		set_csr(CSR_EN);
		for (int i = 0; i < N_TX; i++)
			push_tx(next_random());
		wait_tx_drained();
		finish_test("transmit");

		// Receive with two frames per round to fill the FIFO
		for (int r = 0; r < N_RX_ROUNDS; r++) begin
			for (int i = 0; i < FIFO_DEPTH; i++) begin
				b = next_random();
				rx_expect.push_back(b);
				send_frame(b, 1'b1);
			end
			wait_rx_count(FIFO_DEPTH);
			for (int i = FIFO_DEPTH; i > 0; i--) begin
				check_rx_status(i);
				read_rx_byte();
			end
			check_rx_status(0);
		end
		finish_test("receive");

		// Underflow on an empty RX read, then clear
		read_reg(ADDR_RX, data);
		read_reg(ADDR_FSTAT, fstat);
		check_value("rxunder", 32'(fstat[FSTAT_RX_SHIFT + FSTAT_UNDER_BIT]), 32'd1);
		write_reg(ADDR_FSTAT, 32'(1) << (FSTAT_RX_SHIFT + FSTAT_UNDER_BIT));
		read_reg(ADDR_FSTAT, fstat);
		check_value("rxunder", 32'(fstat[FSTAT_RX_SHIFT + FSTAT_UNDER_BIT]), 32'd0);

		// The tail of a low stop bit looks like a new start so the receiver is re-armed
		send_frame(next_random(), 1'b0);
		set_csr(32'd0);
		set_csr(CSR_EN);
		check_rx_status(0);
		b = next_random();
		rx_expect.push_back(b);
		send_frame(b, 1'b1);
		wait_rx_count(1);
		read_rx_byte();
		read_reg(ADDR_FSTAT, fstat);
		check_value("rxover", 32'(fstat[FSTAT_RX_SHIFT + FSTAT_OVER_BIT]), 32'd0);

		// Overflow with the transmitter stopped
		set_csr(32'd0);
		for (int i = 0; i <= FIFO_DEPTH; i++) begin
			b = next_random();
			write_reg(ADDR_TX, 32'(b));
			if (i < FIFO_DEPTH)
				tx_expect.push_back(b);
		end
		read_reg(ADDR_FSTAT, fstat);
		check_value("tx level", 32'(fstat[7:0]), 32'(FIFO_DEPTH));
		check_value("txfull", 32'(fstat[FSTAT_FULL_BIT]), 32'd1);
		check_value("txover", 32'(fstat[FSTAT_OVER_BIT]), 32'd1);
		check_irq(1'b1, 1'b1);
		write_reg(ADDR_FSTAT, 32'(1) << FSTAT_OVER_BIT);
		read_reg(ADDR_FSTAT, fstat);
		check_value("txover", 32'(fstat[FSTAT_OVER_BIT]), 32'd0);
		// Waiting bytes keep busy set with the transmitter stopped
		read_reg(ADDR_CSR, data);
		check_value("CSR", data, 32'(1) << CSR_BUSY_BIT);
		// The first byte leaves at once and one more write fills the FIFO again
		set_csr(CSR_EN | CSR_TXIE);
		push_tx(next_random());
		check_irq(1'b1, 1'b1);
		wait_tx_drained();
		finish_test("faults");

		// Loopback with the RX interrupt, then the TX interrupt
		set_csr(CSR_EN | CSR_LOOP | CSR_RXIE);
		check_irq(1'b0, 1'b1);
		for (int r = 0; r < N_LOOP_ROUNDS; r++) begin
			for (int i = 0; i < FIFO_DEPTH; i++) begin
				b = next_random();
				rx_expect.push_back(b);
				push_tx(b);
			end
			wait_rx_count(FIFO_DEPTH);
			check_irq(1'b0, 1'b0);
			for (int i = 0; i < FIFO_DEPTH; i++)
				read_rx_byte();
			check_irq(1'b0, 1'b1);
		end
		wait_tx_drained();
		set_csr(CSR_EN | CSR_LOOP | CSR_RXIE | CSR_TXIE);
		check_irq(1'b0, 1'b1);
		set_csr(32'd0);
		check_irq(1'b0, 1'b1);
		finish_test("loopback and interrupt");

		$display("%0d tests run, %0d failed, %0d check errors",
			test_count, failed_tests, error_count);
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- sim.f
uart_pkg.sv
clkdiv_frac.sv
sync_fifo.sv
uart_regs.sv
uart_tx.sv
uart_rx.sv
uart_mini.sv
tb_clkgen.sv
tb_uart_mini.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_uart_mini
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
